// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

rm -f sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module mem_subsystem_tb \
	-f sim.f -o mem_subsystem_sim > build.log 2>&1 &&
./obj_dir/mem_subsystem_sim | tee sim.log ||
{ echo "build or run failed, see build.log"; exit 1; }

grep -qx "NO ERRORS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+tests
verilog/mem_pkg.sv
verilog/wb_mem_slave.sv
verilog/cmd_arbiter.sv
verilog/mem_controller.sv
verilog/mem_subsystem_top.sv
tests/mem_subsystem_tb.sv

// File: tests/tb_vectors.svh
// memory subsystem test vectors
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int N_VEC = 20;

// one wishbone access and its expected read data
typedef struct packed {
	logic        port;
	logic        we;
	// write data from $random, read data from the reference memory
	logic        rnd;
	logic [31:0] adr;
	logic [31:0] wdata;
	logic [31:0] exp;
} vec_t;

vec_t  vec_tab [N_VEC];
string vec_label [N_VEC];

task automatic add_vector(input int idx, input logic port, input logic we, input logic rnd,
	input logic [31:0] adr, input logic [31:0] wdata, input logic [31:0] exp,
	input string label);
	vec_tab[idx] = '{port, we, rnd, adr, wdata, exp};
	vec_label[idx] = label;
endtask

// writes answer with zero data
task automatic load_vector_table;
	// port, we, rnd, adr, wdata, exp, label
	add_vector(0, 1'b0, 1'b1, 1'b0, 32'h005, 32'h1111_0005, 32'h0, "bank0 write");
	add_vector(1, 1'b0, 1'b0, 1'b0, 32'h005, 32'h0, 32'h1111_0005, "bank0 read");
	add_vector(2, 1'b0, 1'b1, 1'b0, 32'h123, 32'h2222_0123, 32'h0, "bank1 write");
	add_vector(3, 1'b0, 1'b0, 1'b0, 32'h123, 32'h0, 32'h2222_0123, "bank1 read");
	add_vector(4, 1'b1, 1'b1, 1'b0, 32'h2A7, 32'h3333_02A7, 32'h0, "bank2 write");
	add_vector(5, 1'b1, 1'b0, 1'b0, 32'h2A7, 32'h0, 32'h3333_02A7, "bank2 read");
	add_vector(6, 1'b1, 1'b1, 1'b0, 32'h3F0, 32'h4444_03F0, 32'h0, "bank3 write");
	add_vector(7, 1'b1, 1'b0, 1'b0, 32'h3F0, 32'h0, 32'h4444_03F0, "bank3 read");
	// bank 1, rows 1 and 5 alternate
	add_vector(8, 1'b0, 1'b1, 1'b0, 32'h110, 32'h5555_0110, 32'h0, "row1 write");
	add_vector(9, 1'b0, 1'b1, 1'b0, 32'h150, 32'h6666_0150, 32'h0, "row5 miss write");
	add_vector(10, 1'b0, 1'b1, 1'b0, 32'h151, 32'h6666_0151, 32'h0, "row5 hit write");
	add_vector(11, 1'b0, 1'b0, 1'b0, 32'h110, 32'h0, 32'h5555_0110, "row1 miss read");
	add_vector(12, 1'b0, 1'b0, 1'b0, 32'h150, 32'h0, 32'h6666_0150, "row5 miss read");
	add_vector(13, 1'b0, 1'b0, 1'b0, 32'h151, 32'h0, 32'h6666_0151, "row5 hit read");
	// one port writes, the other reads back
	add_vector(14, 1'b0, 1'b1, 1'b0, 32'h2C3, 32'h7777_02C3, 32'h0, "shared write a");
	add_vector(15, 1'b1, 1'b0, 1'b0, 32'h2C3, 32'h0, 32'h7777_02C3, "shared read b");
	// random data
	add_vector(16, 1'b0, 1'b1, 1'b1, 32'h033, 32'h0, 32'h0, "random write a");
	add_vector(17, 1'b1, 1'b1, 1'b1, 32'h344, 32'h0, 32'h0, "random write b");
	add_vector(18, 1'b1, 1'b0, 1'b1, 32'h033, 32'h0, 32'h0, "random read b");
	add_vector(19, 1'b0, 1'b0, 1'b1, 32'h344, 32'h0, 32'h0, "random read a");
endtask

`endif

// File: tests/mem_subsystem_tb.sv
// memory subsystem testbench
`timescale 1ns/10ps

module mem_subsystem_tb;
	import mem_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 10;
	localparam int ACK_LIMIT = 2 * (MISS_CYCLES + 10);
	localparam logic [31:0] EARLY_ADR = 32'h041;
	localparam logic [31:0] EARLY_DATA = 32'hDEAD_BEEF;

	`include "tb_vectors.svh"

	localparam int WATCHDOG_NS = (N_VEC + 20) * (MISS_CYCLES + 20) * CLK_PERIOD
		+ (RST_CYCLES + INIT_CYCLES) * CLK_PERIOD;

	logic        clk;
	logic        rst;
	logic        wbs_cyc_a, wbs_stb_a, wbs_we_a, wbs_ack_a;
	logic [31:0] wbs_adr_a, wbs_dat_wr_a, wbs_dat_rd_a;
	logic        wbs_cyc_b, wbs_stb_b, wbs_we_b, wbs_ack_b;
	logic [31:0] wbs_adr_b, wbs_dat_wr_b, wbs_dat_rd_b;

	int          pass_cnt;
	int          fail_cnt;
	int          cyc_cnt;
	int          seed;
	logic [31:0] ref_mem [MEM_WORDS];

	mem_subsystem_top mem_subsystem_top_inst (
		.clk(clk), .rst(rst),
		.wbs_cyc_a_i(wbs_cyc_a), .wbs_stb_a_i(wbs_stb_a), .wbs_we_a_i(wbs_we_a),
		.wbs_adr_a_i(wbs_adr_a), .wbs_dat_a_i(wbs_dat_wr_a),
		.wbs_dat_a_o(wbs_dat_rd_a), .wbs_ack_a_o(wbs_ack_a),
		.wbs_cyc_b_i(wbs_cyc_b), .wbs_stb_b_i(wbs_stb_b), .wbs_we_b_i(wbs_we_b),
		.wbs_adr_b_i(wbs_adr_b), .wbs_dat_b_i(wbs_dat_wr_b),
		.wbs_dat_b_o(wbs_dat_rd_b), .wbs_ack_b_o(wbs_ack_b)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// free-running cycle count for the ready poll
	always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

	task automatic drive_port(input logic port, input logic en, input logic we,
		input logic [31:0] adr, input logic [31:0] wdata);
		if (port == 1'b0) begin
			wbs_cyc_a = en;
			wbs_stb_a = en;
			wbs_we_a = we;
			wbs_adr_a = adr;
			wbs_dat_wr_a = wdata;
		end else begin
			wbs_cyc_b = en;
			wbs_stb_b = en;
			wbs_we_b = we;
			wbs_adr_b = adr;
			wbs_dat_wr_b = wdata;
		end
	endtask

	// one access, ack and read data sampled on the falling edge
	task automatic wb_access(input logic port, input logic we, input logic [31:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata, output bit acked);
		int waited;
		waited = 0;
		acked = 1'b0;
		@(negedge clk);
		drive_port(port, 1'b1, we, adr, wdata);
		while (!acked && waited < ACK_LIMIT) begin
			@(negedge clk);
			waited++;
			acked = (port == 1'b0) ? wbs_ack_a : wbs_ack_b;
		end
		rdata = (port == 1'b0) ? wbs_dat_rd_a : wbs_dat_rd_b;
		// stb drops, ack follows at the next rising edge
		drive_port(port, 1'b0, 1'b0, 32'h0, 32'h0);
	endtask

	task automatic report_result(input string label, input string sig, input bit acked,
		input logic [31:0] got, input logic [31:0] exp);
		if (!acked) begin
			$display("%s: no ack came within %0d cycles", label, ACK_LIMIT);
			fail_cnt++;
		end else if (got !== exp) begin
			$display("[FAIL] %s: %s got %h expected %h", label, sig, got, exp);
			fail_cnt++;
		end else begin
			$display("[PASS] %s", label);
			pass_cnt++;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		vec_t        v;
		logic [31:0] wdata;
		logic [31:0] exp;
		logic [31:0] rdata;
		logic [31:0] rdata_b;
		bit          acked;
		bit          acked_b;
		int          start_cyc;
		clk = 1'b0;
		rst = 1'b1;
		pass_cnt = 0;
		fail_cnt = 0;
		cyc_cnt = 0;
		seed = 32'h5460;
		drive_port(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
		drive_port(1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
		load_vector_table();
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;

		// controller still in init, bridge answers locally
		wb_access(1'b0, 1'b0, 32'h040, 32'h0, rdata, acked);
		report_result("early read", "wbs_dat_a_o", acked, rdata, ERR_DATA);
		wb_access(1'b0, 1'b1, EARLY_ADR, EARLY_DATA, rdata, acked);
		report_result("early write", "wbs_dat_a_o", acked, rdata, ERR_DATA);
		wb_access(1'b0, 1'b0, ADDR_STATUS, 32'h0, rdata, acked);
		report_result("status before ready", "wbs_dat_a_o", acked, rdata, 32'h0);

		// poll status until ready
		start_cyc = cyc_cnt;
		rdata = '0;
		while (rdata[0] !== 1'b1 && cyc_cnt - start_cyc <= INIT_CYCLES + 20) begin
			wb_access(1'b0, 1'b0, ADDR_STATUS, 32'h0, rdata, acked);
		end
		if (rdata[0] !== 1'b1) begin
			$display("ready bit was not set within %0d cycles", INIT_CYCLES + 20);
			fail_cnt++;
		end else begin
			$display("[PASS] ready after %0d cycles of polling", cyc_cnt - start_cyc);
			pass_cnt++;
		end

		// early write must be gone
		wb_access(1'b0, 1'b0, EARLY_ADR, 32'h0, rdata, acked);
		if (!acked) begin
			$display("early write check: no ack came within %0d cycles", ACK_LIMIT);
			fail_cnt++;
		end else if (rdata === EARLY_DATA) begin
			$display("[FAIL] early write kept: wbs_dat_a_o got %h", rdata);
			fail_cnt++;
		end else begin
			$display("[PASS] early write discarded");
			pass_cnt++;
		end

		for (int i = 0; i < N_VEC; i++) begin
			v = vec_tab[i];
			wdata = (v.rnd && v.we) ? $random(seed) : v.wdata;
			wb_access(v.port, v.we, v.adr, wdata, rdata, acked);
			if (v.we) begin
				ref_mem[v.adr[ADDR_W-1:0]] = wdata;
			end
			exp = (v.rnd && !v.we) ? ref_mem[v.adr[ADDR_W-1:0]] : v.exp;
			report_result(vec_label[i], v.port ? "wbs_dat_b_o" : "wbs_dat_a_o",
				acked, rdata, exp);
		end

		// both ports in the same cycle, writes then reads
		fork
			wb_access(1'b0, 1'b1, 32'h0A0, 32'hA5A5_00A0, rdata, acked);
			wb_access(1'b1, 1'b1, 32'h1B0, 32'h5A5A_01B0, rdata_b, acked_b);
		join
		report_result("collision write a", "wbs_dat_a_o", acked, rdata, 32'h0);
		report_result("collision write b", "wbs_dat_b_o", acked_b, rdata_b, 32'h0);
		fork
			wb_access(1'b0, 1'b0, 32'h0A0, 32'h0, rdata, acked);
			wb_access(1'b1, 1'b0, 32'h1B0, 32'h0, rdata_b, acked_b);
		join
		report_result("collision read a", "wbs_dat_a_o", acked, rdata, 32'hA5A5_00A0);
		report_result("collision read b", "wbs_dat_b_o", acked_b, rdata_b, 32'h5A5A_01B0);

		$display("%0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: verilog/cmd_arbiter.sv
// round-robin command arbiter
`timescale 1ns/10ps

module cmd_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [mem_pkg::N_PORTS-1:0]   cmd_stb_i,
	input  mem_pkg::mem_cmd_t             cmd_i [mem_pkg::N_PORTS],
	input  logic                          busy_i,
	output logic                          mem_cmd_stb_o,
	output mem_pkg::mem_cmd_t             mem_cmd_o,
	input  logic                          mem_rsp_stb_i,
	input  mem_pkg::mem_rsp_t             mem_rsp_i,
	output logic [mem_pkg::N_PORTS-1:0]   rsp_stb_o,
	output mem_pkg::mem_rsp_t             rsp_o
);
	import mem_pkg::*;

	// one slot per port, never more than one command each
	logic [N_PORTS-1:0] pend_q;
	mem_cmd_t           slot_q [N_PORTS];

	// last port granted
	logic [TAG_W-1:0]   ptr_q;

	logic               gnt_valid;
	logic [TAG_W-1:0]   gnt_idx;
	logic               can_issue;

	// controller idle and no strobe still in flight
	assign can_issue = !busy_i && !mem_cmd_stb_o;

	// search starts just past the last grant
	always_comb begin
		int cand;
		gnt_valid = 1'b0;
		gnt_idx = '0;
		for (int k = 1; k <= N_PORTS; k++) begin
			cand = (int'(ptr_q) + k) % N_PORTS;
			if (!gnt_valid && pend_q[cand]) begin
				gnt_valid = 1'b1;
				gnt_idx = TAG_W'(cand);
			end
		end
	end

	always_ff @(posedge clk) begin
		mem_cmd_stb_o <= 1'b0;
		if (rst) begin
			pend_q <= '0;
			ptr_q <= '0;
		end else begin
			// absorb incoming strobes
			for (int i = 0; i < N_PORTS; i++) begin
				if (cmd_stb_i[i]) begin
					pend_q[i] <= 1'b1;
				end
			end
			if (can_issue && gnt_valid) begin
				mem_cmd_stb_o <= 1'b1;
				pend_q[gnt_idx] <= 1'b0;
				ptr_q <= gnt_idx;
			end
		end
	end

	// slot payloads
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (cmd_stb_i[i]) begin
				slot_q[i] <= cmd_i[i];
			end
		end
	end

	// command to the controller, held until the next grant
	always_ff @(posedge clk) begin
		if (can_issue && gnt_valid) begin
			mem_cmd_o <= slot_q[gnt_idx];
		end
	end

	// response goes to the port named by the tag
	always_comb begin
		rsp_stb_o = '0;
		if (mem_rsp_stb_i) begin
			rsp_stb_o[mem_rsp_i.tag] = 1'b1;
		end
	end

	// payload is shared, only the strobe is steered
	assign rsp_o = mem_rsp_i;

endmodule

// File: verilog/mem_controller.sv
// banked sdram controller model
`timescale 1ns/10ps

module mem_controller (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmd_stb_i,
	input  mem_pkg::mem_cmd_t    cmd_i,
	output logic                 rsp_stb_o,
	output mem_pkg::mem_rsp_t    rsp_o,
	output mem_pkg::mem_status_t status_o
);
	import mem_pkg::*;

	// init
	logic [INIT_W-1:0]  init_cnt_q;
	logic               ready_q;

	// command in service
	logic               busy_q;
	logic [LAT_W-1:0]   lat_q;
	mem_cmd_t           cur_q;
	logic               accept;
	logic               done;

	// open row per bank
	logic [N_BANKS-1:0] row_valid_q;
	logic [ROW_W-1:0]   open_row_q [N_BANKS];
	logic [BANK_W-1:0]  cmd_bank;
	logic [ROW_W-1:0]   cmd_row;
	logic               row_hit;

	// storage
	logic [DATA_W-1:0]  mem_q [MEM_WORDS];

	assign cmd_bank = cmd_i.addr[ADDR_W-1 -: BANK_W];
	assign cmd_row = cmd_i.addr[ADDR_W-BANK_W-1 -: ROW_W];
	assign row_hit = row_valid_q[cmd_bank] && (open_row_q[cmd_bank] == cmd_row);

	// only one command at a time
	assign accept = cmd_stb_i && ready_q && !busy_q;
	// last cycle of the latency
	assign done = busy_q && (lat_q == LAT_W'(1));

	// count out the init period, then stay ready
	always_ff @(posedge clk) begin
		if (rst) begin
			init_cnt_q <= '0;
			ready_q <= 1'b0;
		end else if (!ready_q) begin
			init_cnt_q <= init_cnt_q + 1'b1;
			if (init_cnt_q == INIT_W'(INIT_CYCLES - 1)) begin
				ready_q <= 1'b1;
			end
		end
	end

	// busy and latency countdown
	always_ff @(posedge clk) begin
		rsp_stb_o <= 1'b0;
		if (rst) begin
			busy_q <= 1'b0;
			lat_q <= '0;
			row_valid_q <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			// one cycle goes to the strobe itself
			lat_q <= row_hit ? LAT_W'(HIT_CYCLES - 1) : LAT_W'(MISS_CYCLES - 1);
			row_valid_q[cmd_bank] <= 1'b1;
		end else if (done) begin
			// busy falls with the response strobe
			busy_q <= 1'b0;
			rsp_stb_o <= 1'b1;
		end else if (busy_q) begin
			lat_q <= lat_q - 1'b1;
		end
	end

	// command and open row capture
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_q <= cmd_i;
			open_row_q[cmd_bank] <= cmd_row;
		end
	end

	// array access when the latency runs out
	always_ff @(posedge clk) begin
		if (done) begin
			if (cur_q.we) begin
				mem_q[cur_q.addr] <= cur_q.data;
			end
			// writes answer with zero data
			rsp_o.data <= cur_q.we ? '0 : mem_q[cur_q.addr];
			rsp_o.we <= cur_q.we;
			rsp_o.tag <= cur_q.tag;
		end
	end

	assign status_o.ready = ready_q;
	assign status_o.busy = busy_q;

endmodule

// File: verilog/mem_pkg.sv
// memory subsystem shared types
package mem_pkg;

	// port and word geometry
	localparam int N_PORTS = 2;
	localparam int ADDR_W = 10;
	localparam int DATA_W = 32;
	localparam int TAG_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

	// bank in addr[9:8], row in addr[7:4], column below
	localparam int BANK_W = 2;
	localparam int ROW_W = 4;
	localparam int N_BANKS = 1 << BANK_W;
	localparam int MEM_WORDS = 1 << ADDR_W;

	// word address of the status register
	localparam logic [31:0] ADDR_STATUS = 32'h00FFFFFF;

	// controller timing, in clk cycles
	localparam int INIT_CYCLES = 64;
	localparam int HIT_CYCLES = 3;
	localparam int MISS_CYCLES = 6;
	localparam int INIT_W = $clog2(INIT_CYCLES + 1);
	localparam int LAT_W = $clog2(MISS_CYCLES + 1);

	// read data for accesses refused before init is done
	localparam logic [DATA_W-1:0] ERR_DATA = '1;

	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [TAG_W-1:0]  tag;
	} mem_cmd_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              we;
		logic [TAG_W-1:0]  tag;
	} mem_rsp_t;

	typedef struct packed {
		logic busy;
		logic ready;
	} mem_status_t;

endpackage

// File: verilog/mem_subsystem_top.sv
// two-port memory subsystem
`timescale 1ns/10ps

module mem_subsystem_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        wbs_cyc_a_i,
	input  logic        wbs_stb_a_i,
	input  logic        wbs_we_a_i,
	input  logic [31:0] wbs_adr_a_i,
	input  logic [31:0] wbs_dat_a_i,
	output logic [31:0] wbs_dat_a_o,
	output logic        wbs_ack_a_o,
	input  logic        wbs_cyc_b_i,
	input  logic        wbs_stb_b_i,
	input  logic        wbs_we_b_i,
	input  logic [31:0] wbs_adr_b_i,
	input  logic [31:0] wbs_dat_b_i,
	output logic [31:0] wbs_dat_b_o,
	output logic        wbs_ack_b_o
);
	import mem_pkg::*;

	// bridge side of the arbiter
	logic [N_PORTS-1:0] cmd_stb;
	mem_cmd_t           cmd [N_PORTS];
	logic [N_PORTS-1:0] rsp_stb;
	mem_rsp_t           rsp;

	// controller side
	logic               mem_cmd_stb;
	mem_cmd_t           mem_cmd;
	logic               mem_rsp_stb;
	mem_rsp_t           mem_rsp;
	mem_status_t        status;

	// port a
	wb_mem_slave #(.PORT_ID(0)) wb_mem_slave_a_inst (
		.clk(clk), .rst(rst),
		.wbs_cyc_i(wbs_cyc_a_i), .wbs_stb_i(wbs_stb_a_i), .wbs_we_i(wbs_we_a_i),
		.wbs_adr_i(wbs_adr_a_i), .wbs_dat_i(wbs_dat_a_i),
		.wbs_dat_o(wbs_dat_a_o), .wbs_ack_o(wbs_ack_a_o),
		.status_i(status),
		.cmd_stb_o(cmd_stb[0]), .cmd_o(cmd[0]),
		.rsp_stb_i(rsp_stb[0]), .rsp_i(rsp)
	);

	// port b
	wb_mem_slave #(.PORT_ID(1)) wb_mem_slave_b_inst (
		.clk(clk), .rst(rst),
		.wbs_cyc_i(wbs_cyc_b_i), .wbs_stb_i(wbs_stb_b_i), .wbs_we_i(wbs_we_b_i),
		.wbs_adr_i(wbs_adr_b_i), .wbs_dat_i(wbs_dat_b_i),
		.wbs_dat_o(wbs_dat_b_o), .wbs_ack_o(wbs_ack_b_o),
		.status_i(status),
		.cmd_stb_o(cmd_stb[1]), .cmd_o(cmd[1]),
		.rsp_stb_i(rsp_stb[1]), .rsp_i(rsp)
	);

	cmd_arbiter cmd_arbiter_inst (
		.clk(clk), .rst(rst),
		.cmd_stb_i(cmd_stb), .cmd_i(cmd),
		.busy_i(status.busy),
		.mem_cmd_stb_o(mem_cmd_stb), .mem_cmd_o(mem_cmd),
		.mem_rsp_stb_i(mem_rsp_stb), .mem_rsp_i(mem_rsp),
		.rsp_stb_o(rsp_stb), .rsp_o(rsp)
	);

	mem_controller mem_controller_inst (
		.clk(clk), .rst(rst),
		.cmd_stb_i(mem_cmd_stb), .cmd_i(mem_cmd),
		.rsp_stb_o(mem_rsp_stb), .rsp_o(mem_rsp),
		.status_o(status)
	);

endmodule

// File: verilog/wb_mem_slave.sv
// wishbone memory slave bridge
`timescale 1ns/10ps

module wb_mem_slave #(
	parameter int PORT_ID = 0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wbs_cyc_i,
	input  logic                 wbs_stb_i,
	input  logic                 wbs_we_i,
	input  logic [31:0]          wbs_adr_i,
	input  logic [31:0]          wbs_dat_i,
	output logic [31:0]          wbs_dat_o,
	output logic                 wbs_ack_o,
	input  mem_pkg::mem_status_t status_i,
	output logic                 cmd_stb_o,
	output mem_pkg::mem_cmd_t    cmd_o,
	input  logic                 rsp_stb_i,
	input  mem_pkg::mem_rsp_t    rsp_i
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_ACK
	} state_t;

	state_t state_q;
	logic   start;
	logic   is_status;
	logic   refused;

	// new access seen while idle
	assign start = (state_q == S_IDLE) && wbs_cyc_i && wbs_stb_i;
	assign is_status = (wbs_adr_i == ADDR_STATUS);
	// controller still in init
	assign refused = !status_i.ready;

	always_ff @(posedge clk) begin
		// command strobe lasts one cycle
		cmd_stb_o <= 1'b0;
		if (rst) begin
			state_q <= S_IDLE;
			wbs_ack_o <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (start) begin
						if (is_status || refused) begin
							// answered locally without a command
							wbs_ack_o <= 1'b1;
							state_q <= S_ACK;
						end else begin
							cmd_stb_o <= 1'b1;
							state_q <= S_WAIT;
						end
					end
				end
				S_WAIT: begin
					if (rsp_stb_i) begin
						wbs_ack_o <= 1'b1;
						state_q <= S_ACK;
					end
				end
				S_ACK: begin
					// hold ack until the master lets go of stb
					if (!wbs_stb_i) begin
						wbs_ack_o <= 1'b0;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// command payload captured once per access
	always_ff @(posedge clk) begin
		if (start) begin
			cmd_o.we <= wbs_we_i;
			cmd_o.addr <= wbs_adr_i[ADDR_W-1:0];
			cmd_o.data <= wbs_dat_i;
			cmd_o.tag <= TAG_W'(PORT_ID);
		end
	end

	// read data back to the master
	always_ff @(posedge clk) begin
		if (start && is_status) begin
			// ready in bit 0 and busy in bit 1
			wbs_dat_o <= {30'd0, status_i.busy, status_i.ready};
		end else if (start && refused) begin
			wbs_dat_o <= ERR_DATA;
		end else if ((state_q == S_WAIT) && rsp_stb_i) begin
			// controller already sends zero data for writes
			wbs_dat_o <= rsp_i.data;
		end
	end

endmodule
